// File: hdl/systolic_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths, matrix size and vector types shared by the systolic array.
// DIM is fixed here because the packed vector types are sized by it.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package systolic_pkg;

    // Data word and full product widths
    localparam int DATA_W = 16;
    localparam int ACC_W  = 2 * DATA_W;

    // Array is DIM x DIM processing elements
    localparam int DIM = 8;

    // Input strobe to output strobe, skew and deskew included
    localparam int LATENCY = 2 * DIM - 1;

    // One element of x, w or z
    typedef logic signed [DATA_W-1:0] data_t;

    // Full signed product before scaling
    typedef logic signed [ACC_W-1:0] prod_t;

    // One row or column vector, element 0 in the low bits
    typedef data_t [DIM-1:0] vec_t;

    // Weight matrix, indexed [row][column]
    typedef vec_t [DIM-1:0] mat_t;

    // One strobed vector
    typedef struct packed {
        logic valid;
        vec_t data;
    } beat_t;

endpackage

// File: hdl/matrix_pe.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Product is scaled down by FRAC_W and truncated to DATA_W bits;
// the accumulation wraps around with no saturation.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module matrix_pe
    import systolic_pkg::*;
#(
    parameter int FRAC_W = 8
) (
    input  logic  clk,
    input  logic  rst,
    input  data_t x_in,
    input  data_t z_in,
    input  data_t w,
    output data_t x_out,
    output data_t z_out
);

    prod_t prod;
    prod_t prod_shifted;
    data_t prod_trunc;
    data_t sum;

    // Full precision product, both operands signed
    assign prod = prod_t'(x_in) * prod_t'(w);

    // Drop the fraction bits, keep the low word
    assign prod_shifted = prod >>> FRAC_W;
    assign prod_trunc   = prod_shifted[DATA_W-1:0];

    // 16-bit add wraps on overflow
    assign sum = z_in + prod_trunc;

    always_ff @(posedge clk) begin
        if (rst) begin
            x_out <= '0;
            z_out <= '0;
        end else begin
            x_out <= x_in;
            z_out <= sum;
        end
    end

endmodule

// File: hdl/systolic_array.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Expects x already skewed by row; column c of z lags by DIM+c cycles.
// A weight load mixes results for vectors still in flight.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module systolic_array
    import systolic_pkg::*;
#(
    parameter int FRAC_W = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic w_load,
    input  mat_t w_data,
    input  vec_t x,
    output vec_t z
);

    mat_t w_reg;

    // x_link[r][c] feeds the x input of element (r, c)
    data_t x_link [DIM][DIM+1];

    // z_link[r][c] feeds the partial sum input of element (r, c)
    data_t z_link [DIM+1][DIM];

    // Weight matrix register, new values used from the next cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            w_reg <= '0;
        end else if (w_load) begin
            w_reg <= w_data;
        end
    end

    for (genvar r = 0; r < DIM; r++) begin : g_row_in
        assign x_link[r][0] = x[r];
    end

    // Bottom row starts every column sum at zero
    for (genvar c = 0; c < DIM; c++) begin : g_col_edge
        assign z_link[0][c] = '0;
        assign z[c]         = z_link[DIM][c];
    end

    // Row 0 is the bottom row, sums move upward one row per cycle
    for (genvar r = 0; r < DIM; r++) begin : g_row
        for (genvar c = 0; c < DIM; c++) begin : g_col
            matrix_pe #(
                .FRAC_W (FRAC_W)
            ) u_pe (
                .clk   (clk),
                .rst   (rst),
                .x_in  (x_link[r][c]),
                .z_in  (z_link[r][c]),
                .w     (w_reg[r][c]),
                .x_out (x_link[r][c+1]),
                .z_out (z_link[r+1][c])
            );
        end
    end

endmodule

// File: hdl/input_skew.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Row r of each vector leaves r cycles after entry; row 0 and the
// valid bit pass straight through.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module input_skew
    import systolic_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  beat_t x_in,
    output vec_t  x_skew,
    output logic  valid_d
);

    // Valid is realigned in the output stage
    assign valid_d = x_in.valid;

    // Row 0 enters the array in the same cycle
    assign x_skew[0] = x_in.data[0];

    for (genvar r = 1; r < DIM; r++) begin : g_row
        // Shift register r stages long
        data_t stage [r];

        always_ff @(posedge clk) begin
            if (rst) begin
                for (int i = 0; i < r; i++) begin
                    stage[i] <= '0;
                end
            end else begin
                stage[0] <= x_in.data[r];
                for (int i = 1; i < r; i++) begin
                    stage[i] <= stage[i-1];
                end
            end
        end

        assign x_skew[r] = stage[r-1];
    end

endmodule

// File: hdl/output_deskew.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Column c is held back DIM-1-c cycles so all columns line up.
// The valid bit is delayed by the full LATENCY of the datapath.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module output_deskew
    import systolic_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  vec_t  z_raw,
    input  logic  valid_d,
    output beat_t z_out
);

    logic [LATENCY-1:0] valid_sr;
    vec_t               z_aligned;

    // Valid delay line, one stage per cycle of datapath latency
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[LATENCY-2:0], valid_d};
        end
    end

    // Last column already arrives last
    assign z_aligned[DIM-1] = z_raw[DIM-1];

    for (genvar c = 0; c < DIM - 1; c++) begin : g_col
        localparam int DEPTH = DIM - 1 - c;

        data_t stage [DEPTH];

        always_ff @(posedge clk) begin
            if (rst) begin
                for (int i = 0; i < DEPTH; i++) begin
                    stage[i] <= '0;
                end
            end else begin
                stage[0] <= z_raw[c];
                for (int i = 1; i < DEPTH; i++) begin
                    stage[i] <= stage[i-1];
                end
            end
        end

        assign z_aligned[c] = stage[DEPTH-1];
    end

    // Strobe marks the cycle where every column holds the same vector
    assign z_out.valid = valid_sr[LATENCY-1];
    assign z_out.data  = z_aligned;

endmodule

// File: hdl/matrix_mult_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// z_out follows x_in by LATENCY cycles; no back-pressure anywhere.
// Load weights only while the array is drained.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module matrix_mult_top
    import systolic_pkg::*;
#(
    parameter int FRAC_W = 8
) (
    input  logic  clk,
    input  logic  rst,
    input  beat_t x_in,
    input  logic  w_load,
    input  mat_t  w_data,
    output beat_t z_out
);

    vec_t x_skew;
    vec_t z_raw;
    logic valid_d;

    // Row r of the input held back r cycles
    input_skew u_input_skew (
        .clk     (clk),
        .rst     (rst),
        .x_in    (x_in),
        .x_skew  (x_skew),
        .valid_d (valid_d)
    );

    systolic_array #(
        .FRAC_W (FRAC_W)
    ) u_systolic_array (
        .clk    (clk),
        .rst    (rst),
        .w_load (w_load),
        .w_data (w_data),
        .x      (x_skew),
        .z      (z_raw)
    );

    // Columns realigned and valid delayed to match
    output_deskew u_output_deskew (
        .clk     (clk),
        .rst     (rst),
        .z_raw   (z_raw),
        .valid_d (valid_d),
        .z_out   (z_out)
    );

endmodule

// File: verification/matrix_mult_ref.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model for one output vector and the expected-vector queue.
// Included inside the testbench module, after systolic_pkg is imported.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MATRIX_MULT_REF_SVH
`define MATRIX_MULT_REF_SVH

// One expected output vector with the cycle its input was taken
typedef struct packed {
    logic signed [31:0] stamp;
    vec_t               data;
} expect_t;

expect_t expect_q[$];

// z[c] is the sum over r of x[r] * w[r][c]. Each product is scaled down
// by frac_w bits, and the low DATA_W bits of the total are kept
function automatic vec_t ref_product(input vec_t x, input mat_t w, input int frac_w);
    vec_t  z;
    data_t xv;
    data_t wv;
    int    acc;
    int    p;
    for (int c = 0; c < DIM; c++) begin
        acc = 0;
        for (int r = 0; r < DIM; r++) begin
            xv  = x[r];
            wv  = w[r][c];
            p   = int'(xv) * int'(wv);
            acc = acc + (p >>> frac_w);
        end
        // Keeping the low bits of the total equals adding with wraparound
        z[c] = acc[DATA_W-1:0];
    end
    return z;
endfunction

// Queue a result that is due LATENCY cycles after its input edge
task automatic push_expect(input vec_t z, input int stamp);
    expect_t e;
    e.stamp = stamp;
    e.data  = z;
    expect_q.push_back(e);
endtask

function automatic int due_cycle(input expect_t e);
    return int'(e.stamp) + LATENCY;
endfunction

`endif

// File: verification/matrix_mult_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Checks every output strobe against the reference model, in order.
// The cycle count is the number of rising edges since time zero.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module matrix_mult_tb
    import systolic_pkg::*;
();

    localparam int FRAC_W    = 8;
    localparam int DRAIN_MAX = 4 * LATENCY;

    logic  clk = 1'b0;
    logic  rst;
    beat_t x_in;
    logic  w_load;
    mat_t  w_data;
    beat_t z_out;

    int   seed;
    int   cyc;
    int   errors;
    int   checks;
    int   strobes;
    int   tests_run;
    int   tests_failed;
    int   errors_mark;
    mat_t w_model;

    `include "matrix_mult_ref.svh"

    matrix_mult_top #(
        .FRAC_W (FRAC_W)
    ) dut (
        .clk    (clk),
        .rst    (rst),
        .x_in   (x_in),
        .w_load (w_load),
        .w_data (w_data),
        .z_out  (z_out)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    // Outputs are read before this edge updates them
    always @(posedge clk) begin
        cyc = cyc + 1;
        check_output();
    end

    task automatic check_output();
        expect_t head;
        if (expect_q.size() > 0 && !z_out.valid && due_cycle(expect_q[0]) <= cyc) begin
            head = expect_q.pop_front();
            errors++;
            $display("missing output strobe for the vector taken in cycle %0d", head.stamp);
        end else if (z_out.valid) begin
            strobes++;
            if (expect_q.size() == 0) begin
                errors++;
                $display("output strobe in cycle %0d with no vector in flight", cyc);
            end else begin
                head = expect_q.pop_front();
                checks++;
                if (due_cycle(head) != cyc) begin
                    errors++;
                    $display("output strobe in cycle %0d, expected in cycle %0d",
                             cyc, due_cycle(head));
                end else begin
                    for (int c = 0; c < DIM; c++) begin
                        if (z_out.data[c] !== head.data[c]) begin
                            errors++;
                            $display("[FAIL] z_out.data[%0d] expected %h actual %h",
                                     c, head.data[c], z_out.data[c]);
                        end
                    end
                end
            end
        end
    endtask

    function automatic data_t rand_word();
        logic [31:0] r;
        r = $random(seed);
        return r[DATA_W-1:0];
    endfunction

    function automatic vec_t rand_vector();
        vec_t v;
        for (int i = 0; i < DIM; i++) begin
            v[i] = rand_word();
        end
        return v;
    endfunction

    function automatic mat_t rand_matrix();
        mat_t m;
        for (int i = 0; i < DIM; i++) begin
            m[i] = rand_vector();
        end
        return m;
    endfunction

    // Input is taken at the rising edge after this falling edge
    task automatic drive_vector(input vec_t x, input vec_t expected);
        @(negedge clk);
        x_in.valid = 1'b1;
        x_in.data  = x;
        push_expect(expected, cyc + 1);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            x_in.valid = 1'b0;
        end
    endtask

    task automatic load_weights(input mat_t m);
        @(negedge clk);
        x_in.valid = 1'b0;
        w_load     = 1'b1;
        w_data     = m;
        w_model    = m;
        @(negedge clk);
        w_load = 1'b0;
    endtask

    task automatic wait_drain(input string what);
        int n;
        n = 0;
        @(negedge clk);
        x_in.valid = 1'b0;
        while (expect_q.size() > 0 && n < DRAIN_MAX) begin
            @(negedge clk);
            n++;
        end
        if (expect_q.size() > 0) begin
            errors++;
            $display("timed out waiting for the array to drain in %s", what);
            expect_q.delete();
        end
    endtask

    task automatic begin_test();
        errors_mark = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != errors_mark) begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     errors - errors_mark);
        end else begin
            $display("test %0d %s: passed", tests_run, name);
        end
    endtask

    initial begin
        vec_t v;
        mat_t m;
        int   mark;
        seed         = 32'hc755_db2a;
        cyc          = 0;
        errors       = 0;
        checks       = 0;
        strobes      = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst          = 1'b1;
        x_in         = '0;
        w_load       = 1'b0;
        w_data       = '0;
        w_model      = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        // Any strobe here is flagged by the checker
        begin_test();
        idle_cycles(20);
        end_test("quiet after reset");

        begin_test();
        m = '0;
        for (int i = 0; i < DIM; i++) begin
            m[i][i] = 16'sd256;
        end
        load_weights(m);
        v = rand_vector();
        drive_vector(v, v);
        wait_drain("identity weights");
        end_test("identity weights");

        begin_test();
        load_weights(rand_matrix());
        for (int i = 0; i < 20; i++) begin
            v = rand_vector();
            drive_vector(v, ref_product(v, w_model, FRAC_W));
            idle_cycles(19);
        end
        wait_drain("single vectors");
        end_test("random single vectors");

        begin_test();
        mark = strobes;
        for (int i = 0; i < 40; i++) begin
            v = rand_vector();
            drive_vector(v, ref_product(v, w_model, FRAC_W));
        end
        wait_drain("back to back");
        if (strobes - mark != 40) begin
            errors++;
            $display("back to back run gave %0d output strobes instead of 40", strobes - mark);
        end
        end_test("back to back");

        begin_test();
        load_weights(rand_matrix());
        for (int i = 0; i < 12; i++) begin
            v = rand_vector();
            drive_vector(v, ref_product(v, w_model, FRAC_W));
            idle_cycles(i % 3);
        end
        wait_drain("weight reload");
        end_test("weight reload");

        begin_test();
        for (int i = 0; i < 8; i++) begin
            v = rand_vector();
            drive_vector(v, ref_product(v, w_model, FRAC_W));
        end
        idle_cycles(3);
        // Nothing is due yet, so the flush cannot hide a strobe
        @(negedge clk);
        rst = 1'b1;
        expect_q.delete();
        repeat (2) @(negedge clk);
        rst  = 1'b0;
        mark = strobes;
        idle_cycles(30);
        if (strobes != mark) begin
            errors++;
            $display("%0d output strobes appeared after reset with no new input",
                     strobes - mark);
        end
        // Reset clears the weights as well
        load_weights(w_model);
        v = rand_vector();
        drive_vector(v, ref_product(v, w_model, FRAC_W));
        wait_drain("reset mid-stream");
        if (strobes - mark != 1) begin
            errors++;
            $display("vector after reset gave %0d output strobes instead of 1", strobes - mark);
        end
        end_test("reset mid-stream");

        $display("tests %0d, failed %0d, vectors checked %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+verification
hdl/systolic_pkg.sv
hdl/matrix_pe.sv
hdl/systolic_array.sv
hdl/input_skew.sv
hdl/output_deskew.sv
hdl/matrix_mult_top.sv
verification/matrix_mult_tb.sv

// File: Makefile
# Verilator build and run of the systolic array testbench

TOP := matrix_mult_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, pass if NO ERRORS is printed"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 -f src.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "NO ERRORS"; then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir
